//--- video_pkg.sv
package video_pkg;

	// colour component depth
	localparam int component_depth = 8;

	// line buffer ring geometry
	localparam int line_buffer_size = 1024;
	localparam int line_buffer_count = 8;

	// pixel and line counters, wide enough for 2047
	localparam int pos_width = 11;

	// index into the ring of line buffers
	localparam int line_idx_width = 3;

	// one colour component
	typedef logic [component_depth-1:0] component_t;

	// pixel position, line count or measured size
	typedef logic [pos_width-1:0] pos_t;

	// ring line index
	typedef logic [line_idx_width-1:0] line_idx_t;

endpackage

//--- scale_pkg.sv
package scale_pkg;

	import video_pkg::*;

	// fractional bits of a step size
	localparam int delta_precision = 8;

	// quotient covers a full pos_t integer part plus the fraction
	localparam int quot_width = delta_precision + pos_width;

	// one integer bit, so 1.0 is the largest step
	typedef logic [delta_precision:0] delta_t;

	typedef logic [quot_width-1:0] hacc_t;
	typedef logic [quot_width-1:0] vacc_t;

	typedef enum logic [1:0] {step_idle, step_div_width, step_div_height} stepper_state_t;

	typedef enum logic {div_idle, div_run} divider_state_t;

endpackage

//--- video_if.sv
`timescale 1ns/1ns

interface video_if import video_pkg::*; ();

	logic hsync;
	logic vsync;
	logic hblank;
	logic vblank;
	component_t red;
	component_t green;
	component_t blue;

	modport source (
		output hsync, vsync, hblank, vblank, red, green, blue
	);

	modport sink (
		input hsync, vsync, hblank, vblank, red, green, blue
	);

endinterface

//--- line_buf_if.sv
`timescale 1ns/1ns

// write side of the line ring, one pixel per enabled edge
interface buf_wr_if import video_pkg::*; ();

	logic en;
	pos_t pos;
	line_idx_t line;
	component_t red;
	component_t green;
	component_t blue;

	modport writer (output en, pos, line, red, green, blue);

	modport store (input en, pos, line, red, green, blue);

endinterface

// read side, data comes back one cycle after the address
interface buf_rd_if import video_pkg::*; ();

	pos_t pos;
	line_idx_t line;
	component_t red;
	component_t green;
	component_t blue;

	modport reader (output pos, line, input red, green, blue);

	modport store (input pos, line, output red, green, blue);

endinterface

//--- input_timing.sv
`timescale 1ns/1ns

module input_timing import video_pkg::*; (
	input logic pixel_clk_a,
	input logic rst,
	video_if.sink vid,
	buf_wr_if.writer wr,
	output pos_t in_width,
	output pos_t in_height,
	output line_idx_t sof_line
);

	logic hsync_q;
	logic vsync_q;
	logic hsync_fall;
	logic vsync_fall;
	logic pixel_active;
	pos_t pixel_count;
	pos_t line_count;
	line_idx_t line_idx;

	assign hsync_fall = hsync_q & ~vid.hsync;
	assign vsync_fall = vsync_q & ~vid.vsync;

	// outside both blankings
	assign pixel_active = ~vid.hblank & ~vid.vblank;

	// active pixels go straight into the current ring line
	assign wr.en = pixel_active;
	assign wr.pos = pixel_count;
	assign wr.line = line_idx;
	assign wr.red = vid.red;
	assign wr.green = vid.green;
	assign wr.blue = vid.blue;

	always_ff @(posedge pixel_clk_a) begin
		if (rst) begin
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			pixel_count <= '0;
			line_count <= '0;
			line_idx <= '0;
			in_width <= '0;
			in_height <= '0;
			sof_line <= '0;
		end else begin
			hsync_q <= vid.hsync;
			vsync_q <= vid.vsync;

			if (hsync_fall) begin
				// blank lines keep the last measured width
				if (pixel_count != '0)
					in_width <= pixel_count;
				pixel_count <= '0;
				if (line_idx == line_idx_t'(line_buffer_count - 1))
					line_idx <= '0;
				else
					line_idx <= line_idx + 1'b1;
			end else if (pixel_active) begin
				pixel_count <= pixel_count + 1'b1;
			end

			if (vsync_fall) begin
				in_height <= line_count;
				line_count <= '0;
				// ring line that precedes the first line of this frame
				sof_line <= line_idx;
			end else if (hsync_fall) begin
				line_count <= line_count + 1'b1;
			end
		end
	end

	// lines wider than a buffer would wrap onto other data
	assert property (@(posedge pixel_clk_a) disable iff (rst)
		wr.en |-> (wr.pos < line_buffer_size));

endmodule

//--- line_store.sv
`timescale 1ns/1ns

module line_store import video_pkg::*; (
	input logic pixel_clk_a,
	buf_wr_if.store wr,
	buf_rd_if.store rd
);

	// one array per component, line then pixel
	component_t red_mem [line_buffer_count][line_buffer_size];
	component_t green_mem [line_buffer_count][line_buffer_size];
	component_t blue_mem [line_buffer_count][line_buffer_size];

	logic [$clog2(line_buffer_size)-1:0] wr_addr;
	logic [$clog2(line_buffer_size)-1:0] rd_addr;

	// positions beyond the buffer are caught by the writer and reader
	assign wr_addr = wr.pos[$clog2(line_buffer_size)-1:0];
	assign rd_addr = rd.pos[$clog2(line_buffer_size)-1:0];

	always_ff @(posedge pixel_clk_a) begin
		if (wr.en) begin
			red_mem[wr.line][wr_addr] <= wr.red;
			green_mem[wr.line][wr_addr] <= wr.green;
			blue_mem[wr.line][wr_addr] <= wr.blue;
		end
	end

	// registered read, always enabled
	always_ff @(posedge pixel_clk_a) begin
		rd.red <= red_mem[rd.line][rd_addr];
		rd.green <= green_mem[rd.line][rd_addr];
		rd.blue <= blue_mem[rd.line][rd_addr];
	end

endmodule

//--- ratio_divider.sv
`timescale 1ns/1ns

module ratio_divider import scale_pkg::*; (
	input logic pixel_clk_a,
	input logic rst,
	input logic start,
	input logic [quot_width-1:0] dividend,
	input logic [quot_width-1:0] divisor,
	output logic [quot_width-1:0] quotient,
	output logic done
);

	typedef logic [$clog2(quot_width+1)-1:0] bit_cnt_t;

	divider_state_t state;
	bit_cnt_t bits_left;
	logic [quot_width-1:0] rem;
	logic [quot_width-1:0] quot_q;
	logic [quot_width-1:0] divisor_q;
	logic [quot_width:0] rem_shift;
	logic [quot_width:0] rem_diff;

	// dividend bits leave from the top, quotient bits enter at the bottom
	assign rem_shift = {rem, quot_q[quot_width-1]};
	assign rem_diff = rem_shift - {1'b0, divisor_q};
	assign quotient = quot_q;

	always_ff @(posedge pixel_clk_a) begin
		if (rst) begin
			state <= div_idle;
			bits_left <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				div_idle: begin
					if (start) begin
						state <= div_run;
						bits_left <= bit_cnt_t'(quot_width);
					end
				end
				div_run: begin
					bits_left <= bits_left - 1'b1;
					if (bits_left == bit_cnt_t'(1)) begin
						state <= div_idle;
						done <= 1'b1;
					end
				end
				default: state <= div_idle;
			endcase
		end
	end

	always_ff @(posedge pixel_clk_a) begin
		if (state == div_idle && start) begin
			rem <= '0;
			quot_q <= dividend;
			divisor_q <= divisor;
		end else if (state == div_run) begin
			// negative trial difference means restore
			if (rem_diff[quot_width])
				rem <= rem_shift[quot_width-1:0];
			else
				rem <= rem_diff[quot_width-1:0];
			quot_q <= {quot_q[quot_width-2:0], ~rem_diff[quot_width]};
		end
	end

	// the stepper must wait for done before the next request
	assert property (@(posedge pixel_clk_a) disable iff (rst)
		(state == div_run) |-> !start);

endmodule

//--- scale_stepper.sv
`timescale 1ns/1ns

module scale_stepper import video_pkg::*, scale_pkg::*; (
	input logic pixel_clk_a,
	input logic rst,
	input logic hsync_out,
	input logic vsync_out,
	input logic hblank_out,
	input logic vblank_out,
	input pos_t in_width,
	input pos_t in_height,
	input line_idx_t sof_line,
	buf_rd_if.reader rd,
	output component_t red_out,
	output component_t green_out,
	output component_t blue_out
);

	stepper_state_t state;
	logic hsync_q;
	logic vsync_q;
	logic hsync_fall;
	logic vsync_fall;
	logic pixel_active;
	logic active_q;
	pos_t pixel_count;
	pos_t line_count;
	pos_t out_width;
	pos_t out_height;
	line_idx_t sof_q;
	hacc_t hacc;
	vacc_t vacc;
	delta_t hdelta;
	delta_t vdelta;
	logic div_start;
	logic div_done;
	logic [quot_width-1:0] div_dividend;
	logic [quot_width-1:0] div_divisor;
	logic [quot_width-1:0] div_quotient;

	assign hsync_fall = hsync_q & ~hsync_out;
	assign vsync_fall = vsync_q & ~vsync_out;
	assign pixel_active = ~hblank_out & ~vblank_out;

	// operands follow the division in progress
	always_comb begin
		if (state == step_div_height) begin
			div_dividend = {in_height, {delta_precision{1'b0}}};
			div_divisor = {{(quot_width - pos_width){1'b0}}, out_height};
		end else begin
			div_dividend = {in_width, {delta_precision{1'b0}}};
			div_divisor = {{(quot_width - pos_width){1'b0}}, out_width};
		end
	end

	ratio_divider div0 (
		.pixel_clk_a(pixel_clk_a),
		.rst(rst),
		.start(div_start),
		.dividend(div_dividend),
		.divisor(div_divisor),
		.quotient(div_quotient),
		.done(div_done)
	);

	// integer parts of the accumulators pick the source pixel
	assign rd.pos = hacc[quot_width-1 -: pos_width];
	assign rd.line = sof_q + vacc[delta_precision +: line_idx_width];

	// read data lines up with the registered active flag
	assign red_out = active_q ? rd.red : '0;
	assign green_out = active_q ? rd.green : '0;
	assign blue_out = active_q ? rd.blue : '0;

	always_ff @(posedge pixel_clk_a) begin
		if (rst) begin
			state <= step_idle;
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			active_q <= 1'b0;
			pixel_count <= '0;
			line_count <= '0;
			out_width <= '0;
			out_height <= '0;
			sof_q <= '0;
			hacc <= '0;
			vacc <= '0;
			hdelta <= '0;
			vdelta <= '0;
			div_start <= 1'b0;
		end else begin
			hsync_q <= hsync_out;
			vsync_q <= vsync_out;
			active_q <= pixel_active;
			div_start <= 1'b0;

			if (hsync_fall) begin
				if (pixel_count != '0)
					out_width <= pixel_count;
				pixel_count <= '0;
				hacc <= '0;
			end else if (pixel_active) begin
				pixel_count <= pixel_count + 1'b1;
				hacc <= hacc + hacc_t'(hdelta);
			end

			if (vsync_fall) begin
				out_height <= line_count;
				line_count <= '0;
				vacc <= '0;
				sof_q <= sof_line;
			end else if (hsync_fall) begin
				line_count <= line_count + 1'b1;
				vacc <= vacc + vacc_t'(vdelta);
			end

			// width then height, once per output frame
			case (state)
				step_idle: begin
					if (vsync_fall && in_width != '0 && in_height != '0 &&
							out_width != '0 && line_count != '0) begin
						state <= step_div_width;
						div_start <= 1'b1;
					end
				end
				step_div_width: begin
					if (div_done) begin
						hdelta <= div_quotient[delta_precision:0];
						state <= step_div_height;
						div_start <= 1'b1;
					end
				end
				step_div_height: begin
					if (div_done) begin
						vdelta <= div_quotient[delta_precision:0];
						state <= step_idle;
					end
				end
				default: state <= step_idle;
			endcase
		end
	end

	// source position must land inside the buffer the input wrote
	assert property (@(posedge pixel_clk_a) disable iff (rst)
		pixel_active |-> (rd.pos < line_buffer_size));

endmodule

//--- upscaler.sv
`timescale 1ns/1ns

module upscaler import video_pkg::*; (
	input logic pixel_clk_a,
	input logic rst,
	input logic hsync_in,
	input logic vsync_in,
	input logic hblank_in,
	input logic vblank_in,
	input component_t red_in,
	input component_t green_in,
	input component_t blue_in,
	input logic hsync_out,
	input logic vsync_out,
	input logic hblank_out,
	input logic vblank_out,
	output component_t red_out,
	output component_t green_out,
	output component_t blue_out
);

	video_if in_vid ();
	buf_wr_if wr_bus ();
	buf_rd_if rd_bus ();

	pos_t in_width;
	pos_t in_height;
	line_idx_t sof_line;

	// input raster into its bundle
	assign in_vid.hsync = hsync_in;
	assign in_vid.vsync = vsync_in;
	assign in_vid.hblank = hblank_in;
	assign in_vid.vblank = vblank_in;
	assign in_vid.red = red_in;
	assign in_vid.green = green_in;
	assign in_vid.blue = blue_in;

	input_timing in_timing0 (
		.pixel_clk_a(pixel_clk_a),
		.rst(rst),
		.vid(in_vid),
		.wr(wr_bus),
		.in_width(in_width),
		.in_height(in_height),
		.sof_line(sof_line)
	);

	line_store store0 (
		.pixel_clk_a(pixel_clk_a),
		.wr(wr_bus),
		.rd(rd_bus)
	);

	scale_stepper stepper0 (
		.pixel_clk_a(pixel_clk_a),
		.rst(rst),
		.hsync_out(hsync_out),
		.vsync_out(vsync_out),
		.hblank_out(hblank_out),
		.vblank_out(vblank_out),
		.in_width(in_width),
		.in_height(in_height),
		.sof_line(sof_line),
		.rd(rd_bus),
		.red_out(red_out),
		.green_out(green_out),
		.blue_out(blue_out)
	);

endmodule

//--- tb_upscaler.sv
`timescale 1ns/1ns

module tb_upscaler import video_pkg::*; ();

	// input raster shared by every test
	localparam int in_w = 16;
	localparam int in_h = 6;
	localparam int frac_one = 256;
	localparam int warmup_pairs = 2;
	localparam int checked_pairs = 2;
	localparam int num_pairs = 4 * (warmup_pairs + checked_pairs);
	// longest pair is one input frame plus the 32x12 output frame
	localparam int max_pair_cycles = (7 + in_h * (in_w + 6)) + (65 + 12 * (32 + 6));
	localparam int timeout_cycles = num_pairs * max_pair_cycles * 2;

	logic pixel_clk_a;
	logic rst;
	logic hsync_in;
	logic vsync_in;
	logic hblank_in;
	logic vblank_in;
	component_t red_in;
	component_t green_in;
	component_t blue_in;
	logic hsync_out;
	logic vsync_out;
	logic hblank_out;
	logic vblank_out;
	component_t red_out;
	component_t green_out;
	component_t blue_out;

	int errors;
	int checks;
	int pixel_checks;
	int cycle_count;

	// input row held by each reference ring line or -1
	int ring_row [line_buffer_count];
	int ring_ptr;
	int in_sof;
	int out_sof;
	int out_line;
	int exp_hdelta;
	int exp_vdelta;

	// staged on the rising edge and checked one cycle later on a falling edge
	logic stage_chk;
	logic stage_pixel;
	component_t stage_red;
	component_t stage_green;
	component_t stage_blue;
	logic pend_chk;
	logic pend_pixel;
	component_t pend_red;
	component_t pend_green;
	component_t pend_blue;

	upscaler dut0 (
		.pixel_clk_a(pixel_clk_a),
		.rst(rst),
		.hsync_in(hsync_in),
		.vsync_in(vsync_in),
		.hblank_in(hblank_in),
		.vblank_in(vblank_in),
		.red_in(red_in),
		.green_in(green_in),
		.blue_in(blue_in),
		.hsync_out(hsync_out),
		.vsync_out(vsync_out),
		.hblank_out(hblank_out),
		.vblank_out(vblank_out),
		.red_out(red_out),
		.green_out(green_out),
		.blue_out(blue_out)
	);

	always #4 pixel_clk_a = ~pixel_clk_a;

	task automatic compare_component(input string name, input component_t actual,
			input component_t expected);
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	always @(negedge pixel_clk_a) begin
		if (pend_chk) begin
			checks++;
			if (pend_pixel)
				pixel_checks++;
			compare_component("red_out", red_out, pend_red);
			compare_component("green_out", green_out, pend_green);
			compare_component("blue_out", blue_out, pend_blue);
		end
		pend_chk = stage_chk;
		pend_pixel = stage_pixel;
		pend_red = stage_red;
		pend_green = stage_green;
		pend_blue = stage_blue;
	end

	always @(posedge pixel_clk_a) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: the run did not end within %0d cycles", timeout_cycles);
			$display("checks: %0d, pixel checks: %0d, errors: %0d", checks, pixel_checks, errors);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic stage_expect(input logic chk, input logic pixel, input int r, input int g,
			input int b);
		stage_chk = chk;
		stage_pixel = pixel;
		stage_red = component_t'(r);
		stage_green = component_t'(g);
		stage_blue = component_t'(b);
	endtask

	task automatic input_cycle(input logic hs, input logic vs, input logic hb, input logic vb,
			input int x, input int y);
		@(posedge pixel_clk_a);
		hsync_in <= hs;
		vsync_in <= vs;
		hblank_in <= hb;
		vblank_in <= vb;
		red_in <= hb ? '0 : component_t'(x);
		green_in <= hb ? '0 : component_t'(y);
		blue_in <= hb ? '0 : component_t'(x + 16 * y);
		// output raster sits blanked meanwhile
		stage_expect(1'b1, 1'b0, 0, 0, 0);
	endtask

	task automatic output_cycle(input logic hs, input logic vs, input logic vb,
			input logic active, input int x, input logic chk);
		int col;
		int row;
		@(posedge pixel_clk_a);
		hsync_out <= hs;
		vsync_out <= vs;
		hblank_out <= ~active;
		vblank_out <= vb;
		if (active) begin
			// nearest source pixel by the floor rule
			col = (x * exp_hdelta) / frac_one;
			row = ring_row[(out_sof + (out_line * exp_vdelta) / frac_one) % line_buffer_count];
			stage_expect(chk, 1'b1, col, row, col + 16 * row);
		end else begin
			stage_expect(1'b1, 1'b0, 0, 0, 0);
		end
	endtask

	task automatic send_input_frame();
		int x;
		int y;
		for (int i = 0; i < 4; i++)
			input_cycle(1'b0, 1'b1, 1'b1, 1'b1, 0, 0);
		// vsync falls next so the ring position marks the frame start
		in_sof = ring_ptr;
		input_cycle(1'b0, 1'b0, 1'b1, 1'b1, 0, 0);
		input_cycle(1'b0, 1'b0, 1'b1, 1'b1, 0, 0);
		for (y = 0; y < in_h; y++) begin
			input_cycle(1'b1, 1'b0, 1'b1, 1'b0, 0, 0);
			input_cycle(1'b1, 1'b0, 1'b1, 1'b0, 0, 0);
			// each hsync fall moves on to the next ring line
			ring_ptr = (ring_ptr + 1) % line_buffer_count;
			ring_row[ring_ptr] = y;
			input_cycle(1'b0, 1'b0, 1'b1, 1'b0, 0, 0);
			input_cycle(1'b0, 1'b0, 1'b1, 1'b0, 0, 0);
			for (x = 0; x < in_w; x++)
				input_cycle(1'b0, 1'b0, 1'b0, 1'b0, x, y);
			input_cycle(1'b0, 1'b0, 1'b1, 1'b0, 0, 0);
			input_cycle(1'b0, 1'b0, 1'b1, 1'b0, 0, 0);
		end
		input_cycle(1'b0, 1'b0, 1'b1, 1'b1, 0, 0);
	endtask

	task automatic play_output_frame(input int w, input int h, input logic chk);
		int x;
		int y;
		out_sof = in_sof;
		out_line = 0;
		for (int i = 0; i < 4; i++)
			output_cycle(1'b0, 1'b1, 1'b1, 1'b0, 0, chk);
		// rest of the 64-cycle vblank leaves room for both divisions
		for (int i = 0; i < 60; i++)
			output_cycle(1'b0, 1'b0, 1'b1, 1'b0, 0, chk);
		for (y = 1; y <= h; y++) begin
			output_cycle(1'b1, 1'b0, 1'b0, 1'b0, 0, chk);
			output_cycle(1'b1, 1'b0, 1'b0, 1'b0, 0, chk);
			out_line = y;
			output_cycle(1'b0, 1'b0, 1'b0, 1'b0, 0, chk);
			output_cycle(1'b0, 1'b0, 1'b0, 1'b0, 0, chk);
			for (x = 0; x < w; x++)
				output_cycle(1'b0, 1'b0, 1'b0, 1'b1, x, chk);
			output_cycle(1'b0, 1'b0, 1'b0, 1'b0, 0, chk);
			output_cycle(1'b0, 1'b0, 1'b0, 1'b0, 0, chk);
		end
		output_cycle(1'b0, 1'b0, 1'b1, 1'b0, 0, chk);
	endtask

	task automatic run_scaling(input string name, input int w, input int h);
		exp_hdelta = (frac_one * in_w) / w;
		exp_vdelta = (frac_one * in_h) / h;
		$display("%s: %0dx%0d to %0dx%0d, hdelta %0d, vdelta %0d",
			name, in_w, in_h, w, h, exp_hdelta, exp_vdelta);
		// new geometry needs two pairs before the deltas settle
		repeat (warmup_pairs) begin
			send_input_frame();
			play_output_frame(w, h, 1'b0);
		end
		repeat (checked_pairs) begin
			send_input_frame();
			play_output_frame(w, h, 1'b1);
		end
	endtask

	task automatic idle_after_reset();
		repeat (8)
			output_cycle(1'b0, 1'b0, 1'b1, 1'b0, 0, 1'b0);
	endtask

	task automatic identity_pass();
		run_scaling("identity", 16, 6);
	endtask

	task automatic fractional_ratio();
		run_scaling("fractional", 24, 9);
	endtask

	task automatic upscale_2x();
		run_scaling("upscale 2x", 32, 12);
	endtask

	task automatic readapt_to_identity();
		run_scaling("back to identity", 16, 6);
	endtask

	initial begin
		pixel_clk_a = 1'b0;
		rst = 1'b1;
		hsync_in = 1'b0;
		vsync_in = 1'b0;
		hblank_in = 1'b1;
		vblank_in = 1'b1;
		red_in = '0;
		green_in = '0;
		blue_in = '0;
		hsync_out = 1'b0;
		vsync_out = 1'b0;
		hblank_out = 1'b1;
		vblank_out = 1'b1;
		errors = 0;
		checks = 0;
		pixel_checks = 0;
		cycle_count = 0;
		ring_ptr = 0;
		in_sof = 0;
		out_sof = 0;
		out_line = 0;
		exp_hdelta = 0;
		exp_vdelta = 0;
		for (int i = 0; i < line_buffer_count; i++)
			ring_row[i] = -1;
		stage_expect(1'b0, 1'b0, 0, 0, 0);
		pend_chk = 1'b0;
		pend_pixel = 1'b0;
		pend_red = '0;
		pend_green = '0;
		pend_blue = '0;

		repeat (4) @(posedge pixel_clk_a);
		rst <= 1'b0;

		idle_after_reset();
		identity_pass();
		fractional_ratio();
		upscale_2x();
		readapt_to_identity();
		idle_after_reset();

		$display("checks: %0d, pixel checks: %0d, errors: %0d", checks, pixel_checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- flist.f
video_pkg.sv
scale_pkg.sv
video_if.sv
line_buf_if.sv
input_timing.sv
line_store.sv
ratio_divider.sv
scale_stepper.sv
upscaler.sv
tb_upscaler.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_upscaler
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)
